// File: hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define CPU_WORD    16   // Data and instruction word
`define CPU_REGS    16   // Register file entries
`define CPU_RIDX    4    // Register index bits

// Memory depths, in words
`define IMEM_WORDS  256
`define DMEM_WORDS  256

// Opcode field spans 16 codes
`define CPU_OPCODES 16

// Immediate field widths
`define LLB_IMM_W   8    // LLB byte immediate
`define MEM_OFF_W   4    // LW/SW signed word offset

`endif

// File: hdl/isa_pkg.sv
`default_nettype none
`include "cpu_params.svh"

package isa_pkg;

  typedef logic [`CPU_WORD-1:0] wordT;    // Data word
  typedef logic [`CPU_RIDX-1:0] regIdxT;  // Register index

  // Opcode field [15:12]; codes not listed decode as no-ops
  typedef enum logic [$clog2(`CPU_OPCODES)-1:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_XOR = 4'd2,
    OP_AND = 4'd3,
    OP_LW  = 4'd8,
    OP_SW  = 4'd9,
    OP_LLB = 4'd10,
    OP_HLT = 4'd15
  } opcodeT;

  // Register format
  typedef struct packed {
    opcodeT op;
    regIdxT rd;   // Destination, or store source for SW
    regIdxT rs;
    regIdxT rt;
  } instrT;

  // LLB view of the same word
  typedef struct packed {
    opcodeT                 op;
    regIdxT                 rd;
    logic [`LLB_IMM_W-1:0]  imm;
  } llbT;

  // LW/SW view
  typedef struct packed {
    opcodeT                 op;
    regIdxT                 rd;
    regIdxT                 base;
    logic [`MEM_OFF_W-1:0]  offset;  // Signed, in words
  } memInstrT;

endpackage

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;
  import isa_pkg::*;

  // Control bundle, all zero for a bubble
  typedef struct packed {
    opcodeT aluOp;
    logic   useImm;     // Second ALU operand is imm
    logic   memRead;    // LW
    logic   memWrite;   // SW
    logic   regWrite;   // Already cleared for rd 0
    logic   memToReg;   // Writeback takes load data
    logic   isHalt;
  } ctrlT;

  ////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////

  typedef struct packed {
    wordT pc;
    wordT instr;
  } ifIdT;

  typedef struct packed {
    ctrlT   ctrl;
    regIdxT rsIdx;    // 0 when rs unused
    regIdxT rtIdx;    // Holds the rd field for SW
    regIdxT rdIdx;
    wordT   rsData;
    wordT   rtData;
    wordT   imm;      // Sign extended
  } idExT;

  typedef struct packed {
    ctrlT   ctrl;
    regIdxT rdIdx;
    wordT   aluRes;     // Result or memory address
    wordT   storeData;
  } exMemT;

  typedef struct packed {
    ctrlT   ctrl;
    regIdxT rdIdx;
    wordT   wbData;
  } memWbT;

endpackage

`default_nettype wire

// File: hdl/fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fwd_if import isa_pkg::*; ();

  // EX/MEM register side
  regIdxT exMemRd;
  logic   exMemWe;
  logic   exMemLoad;   // Load data not ready yet, no bypass
  wordT   exMemData;

  // Writeback side
  regIdxT wbRd;
  logic   wbWe;
  wordT   wbData;

  modport src (output exMemRd, exMemWe, exMemLoad, exMemData, wbRd, wbWe, wbData);

  modport exe (input exMemRd, exMemWe, exMemLoad, exMemData, wbRd, wbWe, wbData);

  // Decode sees the load in flight and writes the register file
  modport dec (input exMemRd, exMemLoad, wbRd, wbWe, wbData);

endinterface

`default_nettype wire

// File: hdl/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

// Generic stage register, one per pipeline boundary
module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic hold,     // Keep current payload
  input  logic bubble,   // Load zero payload, wins over hold
  input  T     d,
  output T     q
);

  always_ff @(posedge clk) begin
    if (rst || bubble) begin
      q <= '0;            // Zero payload is a no-op
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module fetch_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           stall,     // Load-use hold
  input  logic                           haltSeen,  // HLT decoded
  input  logic                           imemWe,
  input  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr,  // Word address
  input  wordT                           imemData,
  output wordT                           pc,
  output ifIdT                           ifId
);

  localparam int IAW = $clog2(`IMEM_WORDS);

  wordT imem [`IMEM_WORDS];   // Instruction store
  wordT pcPlus2;
  logic [IAW-1:0] fetchIdx;

  // Program load only while core is held in reset
  always_ff @(posedge clk) begin
    if (rst && imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  assign pcPlus2  = pc + `CPU_WORD'(2);
  assign fetchIdx = pc[IAW:1];   // Byte PC to word index

  // PC freezes on stall and for good after HLT
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!stall && !haltSeen) begin
      pc <= pcPlus2;
    end
  end

  // Combinational instruction read
  always_comb begin
    ifId.pc    = pc;
    ifId.instr = imem[fetchIdx];
  end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  ifIdT   ifId,
  input  idExT   idExPrev,   // Instruction now in EX
  fwd_if.dec     fwd,
  input  regIdxT dbgReg,
  output wordT   dbgData,
  output logic   stall,
  output logic   haltSeen,
  output idExT   idEx
);

  instrT    ins;
  llbT      llb;
  memInstrT mem;
  ctrlT     ctrl;
  logic     wantWrite;
  logic     usesRs;
  logic     usesRt;
  logic     isStore;
  regIdxT   rsSel;
  regIdxT   rtSel;
  wordT     imm;
  wordT     rsVal;
  wordT     rtVal;
  logic     haltHeld;
  logic     loadInEx;

  wordT regFile [`CPU_REGS];

  // Three views of one instruction word
  assign ins = instrT'(ifId.instr);
  assign llb = llbT'(ifId.instr);
  assign mem = memInstrT'(ifId.instr);

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////

  always_comb begin
    ctrl      = '0;
    wantWrite = 1'b0;
    usesRs    = 1'b0;
    usesRt    = 1'b0;
    isStore   = 1'b0;
    imm       = '0;
    case (ins.op)
      OP_ADD, OP_SUB, OP_XOR, OP_AND: begin
        ctrl.aluOp = ins.op;
        wantWrite  = 1'b1;
        usesRs     = 1'b1;
        usesRt     = 1'b1;
      end
      OP_LLB: begin
        ctrl.aluOp  = OP_LLB;
        ctrl.useImm = 1'b1;
        wantWrite   = 1'b1;
        imm = {{(`CPU_WORD-`LLB_IMM_W){llb.imm[`LLB_IMM_W-1]}}, llb.imm};
      end
      OP_LW: begin
        ctrl.aluOp    = OP_LW;
        ctrl.useImm   = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        wantWrite     = 1'b1;
        usesRs        = 1'b1;   // Base register
        imm = {{(`CPU_WORD-`MEM_OFF_W){mem.offset[`MEM_OFF_W-1]}}, mem.offset};
      end
      OP_SW: begin
        ctrl.aluOp    = OP_SW;
        ctrl.useImm   = 1'b1;
        ctrl.memWrite = 1'b1;
        usesRs        = 1'b1;
        isStore       = 1'b1;   // rd field is the data source
        imm = {{(`CPU_WORD-`MEM_OFF_W){mem.offset[`MEM_OFF_W-1]}}, mem.offset};
      end
      OP_HLT: begin
        ctrl.aluOp  = OP_HLT;
        ctrl.isHalt = 1'b1;
      end
      default: ;                // Other codes act as no-ops
    endcase
    ctrl.regWrite = wantWrite && (ins.rd != '0);   // r0 stays zero
  end

  // Unused operands collapse to index 0, which never matches
  assign rsSel = usesRs ? ins.rs : '0;
  assign rtSel = isStore ? ins.rd : (usesRt ? ins.rt : '0);

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  // Same-cycle writeback shows through on reads
  function automatic wordT readReg(regIdxT idx);
    if (idx == '0) begin
      return '0;
    end
    if (fwd.wbWe && (fwd.wbRd == idx)) begin
      return fwd.wbData;
    end
    return regFile[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst && fwd.wbWe && (fwd.wbRd != '0)) begin
      regFile[fwd.wbRd] <= fwd.wbData;
    end
  end

  always_comb begin
    rsVal   = readReg(rsSel);
    rtVal   = readReg(rtSel);
    dbgData = readReg(dbgReg);   // Debug port
  end

  // Load in EX feeding this instruction costs one bubble
  assign loadInEx = idExPrev.ctrl.memRead && (idExPrev.rdIdx != '0);
  assign stall    = loadInEx && ((idExPrev.rdIdx == rsSel) || (idExPrev.rdIdx == rtSel));

  // Sticky once HLT has passed decode
  always_ff @(posedge clk) begin
    if (rst) begin
      haltHeld <= 1'b0;
    end else if (ins.op == OP_HLT) begin
      haltHeld <= 1'b1;
    end
  end
  assign haltSeen = haltHeld || (ins.op == OP_HLT);

  always_comb begin
    idEx.ctrl   = ctrl;
    idEx.rsIdx  = rsSel;
    idEx.rtIdx  = rtSel;
    idEx.rdIdx  = ins.rd;
    idEx.rsData = rsVal;
    idEx.rtData = rtVal;
    idEx.imm    = imm;
  end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  idExT  idEx,
  fwd_if.exe    fwd,
  output exMemT exMem
);

  wordT opA;      // Bypassed rs
  wordT opB;      // Bypassed rt or store source
  wordT opBImm;   // Second ALU input
  wordT aluRes;

  // Newest producer first, EX/MEM then writeback
  function automatic wordT bypass(regIdxT idx, wordT regVal);
    if (idx == '0) begin
      return regVal;
    end
    if (fwd.exMemWe && !fwd.exMemLoad && (fwd.exMemRd == idx)) begin
      return fwd.exMemData;
    end
    if (fwd.wbWe && (fwd.wbRd == idx)) begin
      return fwd.wbData;
    end
    return regVal;
  endfunction

  ////////////////////////////////////////
  // Operand select and ALU
  ////////////////////////////////////////

  always_comb begin
    opA    = bypass(idEx.rsIdx, idEx.rsData);
    opB    = bypass(idEx.rtIdx, idEx.rtData);
    opBImm = idEx.ctrl.useImm ? idEx.imm : opB;
    case (idEx.ctrl.aluOp)
      OP_ADD, OP_LW, OP_SW: aluRes = opA + opBImm;   // Address gen shares the adder
      OP_SUB:               aluRes = opA - opBImm;
      OP_XOR:               aluRes = opA ^ opBImm;
      OP_AND:               aluRes = opA & opBImm;
      OP_LLB:               aluRes = idEx.imm;        // Pass immediate
      default:              aluRes = '0;
    endcase
  end

  always_comb begin
    exMem.ctrl      = idEx.ctrl;
    exMem.rdIdx     = idEx.rdIdx;
    exMem.aluRes    = aluRes;
    exMem.storeData = opB;   // Store source after bypass
  end

endmodule

`default_nettype wire

// File: hdl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module memory_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  exMemT exMem,
  output memWbT memWb,
  output wordT  wbData    // Selected result in this stage
);

  localparam int DAW = $clog2(`DMEM_WORDS);

  wordT dmem [`DMEM_WORDS];
  logic [DAW-1:0] addr;
  wordT rdData;

  assign addr   = exMem.aluRes[DAW-1:0];   // Word address wraps at depth
  assign rdData = dmem[addr];              // Combinational read

  always_ff @(posedge clk) begin
    if (!rst && exMem.ctrl.memWrite) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  // Writeback select
  assign wbData = exMem.ctrl.memToReg ? rdData : exMem.aluRes;

  always_comb begin
    memWb.ctrl   = exMem.ctrl;
    memWb.rdIdx  = exMem.rdIdx;
    memWb.wbData = wbData;
  end

endmodule

`default_nettype wire

// File: hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu import pipe_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           imemWe,     // Program load, during reset
  input  logic [$clog2(`IMEM_WORDS)-1:0] imemAddr,
  input  logic [`CPU_WORD-1:0]           imemData,
  input  logic [`CPU_RIDX-1:0]           dbgReg,
  output logic [`CPU_WORD-1:0]           dbgData,
  output logic [`CPU_WORD-1:0]           pc,
  output logic                           hlt
);

  ifIdT  ifIdD,  ifIdQ;
  idExT  idExD,  idExQ;
  exMemT exMemD, exMemQ;
  memWbT memWbD, memWbQ;
  logic  stall;
  logic  haltSeen;
  logic  [`CPU_WORD-1:0] memResult;   // MEM stage result

  fwd_if fwdBus ();

  ////////////////////////////////////////
  // IF and IF/ID
  ////////////////////////////////////////

  fetch_stage ifStage (.clk(clk), .rst(rst), .stall(stall), .haltSeen(haltSeen),
                       .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
                       .pc(pc), .ifId(ifIdD));

  // Squash whatever follows HLT
  pipe_reg #(.T(ifIdT)) ifIdReg (.clk(clk), .rst(rst), .hold(stall), .bubble(haltSeen),
                                 .d(ifIdD), .q(ifIdQ));

  ////////////////////////////////////////
  // ID and ID/EX
  ////////////////////////////////////////

  decode_stage idStage (.clk(clk), .rst(rst), .ifId(ifIdQ), .idExPrev(idExQ), .fwd(fwdBus),
                        .dbgReg(dbgReg), .dbgData(dbgData), .stall(stall),
                        .haltSeen(haltSeen), .idEx(idExD));

  pipe_reg #(.T(idExT)) idExReg (.clk(clk), .rst(rst), .hold(1'b0), .bubble(stall),
                                 .d(idExD), .q(idExQ));   // Bubble on load-use

  ////////////////////////////////////////
  // EX, MEM and their registers
  ////////////////////////////////////////

  execute_stage exStage (.idEx(idExQ), .fwd(fwdBus), .exMem(exMemD));

  pipe_reg #(.T(exMemT)) exMemReg (.clk(clk), .rst(rst), .hold(1'b0), .bubble(1'b0),
                                   .d(exMemD), .q(exMemQ));

  memory_stage memStage (.clk(clk), .rst(rst), .exMem(exMemQ), .memWb(memWbD),
                         .wbData(memResult));

  // HLT parks here so hlt stays up
  pipe_reg #(.T(memWbT)) memWbReg (.clk(clk), .rst(rst), .hold(hlt), .bubble(1'b0),
                                   .d(memWbD), .q(memWbQ));

  assign hlt = memWbQ.ctrl.isHalt;

  ////////////////////////////////////////
  // Bypass sources
  ////////////////////////////////////////

  assign fwdBus.exMemRd   = exMemQ.rdIdx;
  assign fwdBus.exMemWe   = exMemQ.ctrl.regWrite;
  assign fwdBus.exMemLoad = exMemQ.ctrl.memRead;
  assign fwdBus.exMemData = memResult;      // Equals aluRes when bypass is allowed
  assign fwdBus.wbRd      = memWbQ.rdIdx;
  assign fwdBus.wbWe      = memWbQ.ctrl.regWrite;
  assign fwdBus.wbData    = memWbQ.wbData;

endmodule

`default_nettype wire

// File: tb/cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions import isa_pkg::*; (
  input logic clk,
  input logic rst,
  input logic stall,
  input logic haltSeen,   // Halt flag in decode
  input wordT decPc,      // PC of the word held in IF/ID
  input wordT decInstr    // Word held in IF/ID
);

  int failCount = 0;   // Failed assertions so far

  // Load-use costs one bubble, never two
  property stallOneCycle;
    @(posedge clk) disable iff (rst) stall |=> !stall;
  endproperty

  // IF/ID holds its word while stalled
  property pcHeldOnStall;
    @(posedge clk) disable iff (rst) stall |=> $stable(decPc);
  endproperty

  // Nothing fetched behind HLT reaches decode
  property haltSquash;
    @(posedge clk) disable iff (rst) haltSeen |=> (decPc == '0) && (decInstr == '0);
  endproperty

  assert property (stallOneCycle) else begin
    failCount++;
    $error("stall held for two cycles");
  end
  assert property (pcHeldOnStall) else begin
    failCount++;
    $error("IF/ID pc moved during a stall");
  end
  assert property (haltSquash) else begin
    failCount++;
    $error("instruction after HLT reached decode");
  end

endmodule

bind decode_stage cpu_assertions decodeChecks (.clk(clk), .rst(rst), .stall(stall),
                                               .haltSeen(haltSeen), .decPc(ifId.pc),
                                               .decInstr(ifId.instr));

`default_nettype wire

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_tb import isa_pkg::*; ();

  localparam int   IAW      = $clog2(`IMEM_WORDS);
  localparam wordT NOP_WORD = 16'h4000;   // Opcode 4 is unassigned
  localparam wordT HLT_WORD = 16'hf000;

  logic           clk;
  logic           rst;
  logic           imemWe;
  logic [IAW-1:0] imemAddr;
  wordT           imemData;
  regIdxT         dbgReg;
  wordT           dbgData;
  wordT           pc;
  logic           hlt;

  wordT   prog [$];                // Program under construction
  int     haltIdx;                 // Word index of the HLT
  wordT   modelReg [`CPU_REGS];    // Expected register values
  logic   touched [`CPU_REGS];     // Written by this program
  wordT   modelMem [`DMEM_WORDS];
  integer seed;
  int     cycleCount;
  int     cycleLimit;

  cpu u_dut (.clk(clk), .rst(rst), .imemWe(imemWe), .imemAddr(imemAddr),
             .imemData(imemData), .dbgReg(dbgReg), .dbgData(dbgData), .pc(pc), .hlt(hlt));

  initial clk = 1'b0;
  always #10 clk = ~clk;   // 20 ns period

  ////////////////////////////////////////
  // Reporting and watchdog
  ////////////////////////////////////////

  task automatic abortRun();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("The tests ran past their cycle limit of %0d", cycleLimit);
      abortRun();
    end
  end

  // Bound decode checks
  always @(u_dut.idStage.decodeChecks.failCount) begin
    if (u_dut.idStage.decodeChecks.failCount != 0) begin
      $display("A bound assertion in decode failed");
      abortRun();
    end
  end

  ////////////////////////////////////////
  // Assembler helpers
  ////////////////////////////////////////

  function automatic wordT encAlu(opcodeT op, regIdxT rd, regIdxT rs, regIdxT rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic wordT encLlb(regIdxT rd, logic [7:0] imm);
    return {OP_LLB, rd, imm};
  endfunction

  function automatic wordT encMem(opcodeT op, regIdxT rd, regIdxT base, logic [3:0] off);
    return {op, rd, base, off};   // Offset counts words, signed
  endfunction

  function automatic logic [7:0] randByte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic addNops(input int n);
    repeat (n) prog.push_back(NOP_WORD);
  endtask

  task automatic addHalt();
    haltIdx = prog.size();
    prog.push_back(HLT_WORD);
  endtask

  ////////////////////////////////////////
  // Reference model, one instruction at a time
  ////////////////////////////////////////

  task automatic writeModel(input regIdxT rd, input wordT val);
    if (rd != '0) begin   // r0 stays zero
      modelReg[rd] = val;
      touched[rd]  = 1'b1;
    end
  endtask

  task automatic runModel();
    int     i;
    wordT   w;
    wordT   addr;
    logic   done;
    regIdxT rd;
    regIdxT rs;
    regIdxT rt;
    for (int r = 0; r < `CPU_REGS; r++) begin
      modelReg[r] = '0;
      touched[r]  = 1'b0;
    end
    i    = 0;
    done = 1'b0;
    while (!done && i < prog.size()) begin
      w    = prog[i];
      rd   = w[11:8];
      rs   = w[7:4];
      rt   = w[3:0];
      addr = modelReg[rs] + {{12{w[3]}}, w[3:0]};   // LW/SW address
      case (opcodeT'(w[15:12]))
        OP_ADD: writeModel(rd, modelReg[rs] + modelReg[rt]);
        OP_SUB: writeModel(rd, modelReg[rs] - modelReg[rt]);
        OP_XOR: writeModel(rd, modelReg[rs] ^ modelReg[rt]);
        OP_AND: writeModel(rd, modelReg[rs] & modelReg[rt]);
        OP_LLB: writeModel(rd, {{8{w[7]}}, w[7:0]});
        OP_LW:  writeModel(rd, modelMem[addr % `DMEM_WORDS]);
        OP_SW:  modelMem[addr % `DMEM_WORDS] = modelReg[rd];   // rd is the source
        OP_HLT: done = 1'b1;
        default: ;
      endcase
      i++;
    end
  endtask

  ////////////////////////////////////////
  // DUT sequencing
  ////////////////////////////////////////

  task automatic loadAndReset();
    @(negedge clk);
    rst = 1'b1;
    foreach (prog[i]) begin
      imemWe   = 1'b1;
      imemAddr = IAW'(i);
      imemData = prog[i];
      @(negedge clk);
    end
    imemWe = 1'b0;
    repeat (2) @(negedge clk);   // Two reset cycles after the load
    rst = 1'b0;
  endtask

  // Counts rising edges from reset release until hlt
  task automatic waitHalt(input int budget, output int cycles);
    cycles = 0;
    while (hlt !== 1'b1) begin
      if (cycles >= budget) begin
        $display("core never halted");
        abortRun();
      end
      @(posedge clk);
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic runProgram(output int cycles);
    cycleLimit += 2 * prog.size() + `CPU_REGS + 25;   // Load, run, readout, halt watch
    loadAndReset();
    waitHalt(prog.size() + 10, cycles);
    runModel();
  endtask

  task automatic checkRegs();
    for (int r = 0; r < `CPU_REGS; r++) begin
      if (r == 0 || touched[r]) begin
        @(negedge clk);
        dbgReg = regIdxT'(r);
        @(posedge clk);
        checkEq($sformatf("dbgData (r%0d)", r), dbgData, modelReg[r]);
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic testAluOps();
    int cyc;
    prog.delete();
    prog.push_back(encLlb(4'd1, randByte()));
    prog.push_back(encLlb(4'd2, randByte()));
    prog.push_back(encLlb(4'd7, 8'h80));   // 0xff80, doubling wraps
    addNops(3);
    prog.push_back(encAlu(OP_ADD, 4'd3, 4'd1, 4'd2));
    addNops(3);
    prog.push_back(encAlu(OP_SUB, 4'd4, 4'd1, 4'd2));
    addNops(3);
    prog.push_back(encAlu(OP_XOR, 4'd5, 4'd1, 4'd2));
    addNops(3);
    prog.push_back(encAlu(OP_AND, 4'd6, 4'd1, 4'd2));
    addNops(3);
    prog.push_back(encAlu(OP_ADD, 4'd8, 4'd7, 4'd7));
    addHalt();
    runProgram(cyc);
    checkRegs();
  endtask

  task automatic testBypass();
    int cyc;
    prog.delete();
    prog.push_back(encLlb(4'd1, randByte()));
    prog.push_back(encLlb(4'd2, randByte()));
    prog.push_back(encAlu(OP_ADD, 4'd3, 4'd1, 4'd2));   // r2 at 1, r1 at 2
    prog.push_back(encAlu(OP_SUB, 4'd4, 4'd3, 4'd2));
    addNops(1);
    prog.push_back(encAlu(OP_XOR, 4'd5, 4'd4, 4'd1));   // Writeback bypass
    addNops(2);
    prog.push_back(encAlu(OP_AND, 4'd6, 4'd5, 4'd3));   // Write-through
    prog.push_back(encAlu(OP_ADD, 4'd7, 4'd6, 4'd6));
    addHalt();
    runProgram(cyc);
    checkRegs();
  endtask

  task automatic testMemory();
    int cyc;
    prog.delete();
    prog.push_back(encLlb(4'd1, randByte()));
    prog.push_back(encLlb(4'd2, 8'h10));
    prog.push_back(encLlb(4'd3, 8'h13));
    prog.push_back(encMem(OP_SW, 4'd1, 4'd2, 4'd5));    // Word 0x15
    prog.push_back(encMem(OP_LW, 4'd4, 4'd3, 4'd2));    // Same word
    prog.push_back(encMem(OP_SW, 4'd2, 4'd3, 4'hd));    // Offset -3
    prog.push_back(encMem(OP_LW, 4'd7, 4'd2, 4'd0));
    prog.push_back(encLlb(4'd0, 8'h55));
    prog.push_back(encAlu(OP_ADD, 4'd0, 4'd1, 4'd1));
    prog.push_back(encAlu(OP_ADD, 4'd5, 4'd0, 4'd1));   // r0 must read zero
    addHalt();
    runProgram(cyc);
    checkRegs();
  endtask

  task automatic testLoadUse();
    int         cyc [2];
    logic [7:0] data;
    data = randByte();
    for (int v = 0; v < 2; v++) begin
      prog.delete();
      prog.push_back(encLlb(4'd1, data));
      prog.push_back(encLlb(4'd2, 8'h20));
      prog.push_back(encMem(OP_SW, 4'd1, 4'd2, 4'd0));
      prog.push_back(encMem(OP_LW, 4'd3, 4'd2, 4'd0));
      prog.push_back(v == 0 ? encAlu(OP_ADD, 4'd4, 4'd3, 4'd1) : NOP_WORD);
      addHalt();
      runProgram(cyc[v]);
      checkRegs();
    end
    checkEq("hlt rise cycle, no dependency", wordT'(cyc[1]), wordT'(haltIdx + 4));
    checkEq("hlt rise cycle, load-use", wordT'(cyc[0]), wordT'(cyc[1] + 1));
  endtask

  task automatic testHalt();
    int   cyc;
    wordT expPc;
    prog.delete();
    prog.push_back(encLlb(4'd1, randByte()));
    prog.push_back(encLlb(4'd2, randByte()));
    prog.push_back(encAlu(OP_ADD, 4'd3, 4'd1, 4'd2));
    addHalt();
    prog.push_back(encLlb(4'd1, 8'h3c));                // Never retires
    prog.push_back(encAlu(OP_ADD, 4'd2, 4'd1, 4'd1));
    prog.push_back(encLlb(4'd3, 8'hc3));
    prog.push_back(HLT_WORD);
    runProgram(cyc);
    expPc = wordT'(2 * haltIdx + 2);   // Frozen one word past HLT
    repeat (10) begin
      @(negedge clk);
      checkEq("pc", pc, expPc);
      checkEq("hlt", wordT'(hlt), 16'd1);
    end
    checkRegs();
  endtask

  initial begin
    rst        = 1'b1;
    imemWe     = 1'b0;
    imemAddr   = '0;
    imemData   = '0;
    dbgReg     = '0;
    seed       = 32'h5ff4_8a1c;
    cycleCount = 0;
    cycleLimit = 10;
    testAluOps();
    testBypass();
    testMemory();
    testLoadUse();
    testHalt();
    @(negedge clk);   // Last edge's assertions settle
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fwd_if.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu.sv
tb/cpu_assertions.sv
tb/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/fwd_if.sv
      - hdl/pipe_reg.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/cpu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/cpu_assertions.sv
      - tb/cpu_tb.sv
